// ==== src/video_pkg.sv ====
//********************
// Video side types for the colour mixer
// Colour words pack blue high, green middle, red low
// PIXEL_DLY must match the fixed fetch and mix latency
//********************

package video_pkg;

    // Width of one colour component
    localparam int COMP_W = 5;

    // Full colour word holds three components
    localparam int RGB_W = 3 * COMP_W;

    // Layer code widths as delivered by the tile engines
    localparam int L1_W = 5;
    localparam int L2_W = 4;

    // Pixel periods from pixel sampling to colour output
    localparam int PIXEL_DLY = 3;

    // Bits of the high palette byte that reach the colour word
    localparam int HI_BITS = RGB_W - 8;

    // First layer code, bit 4 picks the palette bank
    typedef logic [L1_W-1:0] layer1_pxl_t;

    // Second layer code
    typedef logic [L2_W-1:0] layer2_pxl_t;

    // Packed blue, green, red colour
    typedef logic [RGB_W-1:0] rgb15_t;

    // Single colour component
    typedef logic [COMP_W-1:0] colour_comp_t;

endpackage

// ==== src/cpu_bus_pkg.sv ====
//********************
// CPU side types for the palette bus
// Palette is byte wide and byte addressed
//********************

package cpu_bus_pkg;

    // Palette address width in bytes
    localparam int PAL_AW = 10;

    // CPU data bus width
    localparam int DATA_W = 8;

    // Number of palette bytes
    localparam int PAL_BYTES = 1 << PAL_AW;

    // Palette byte address
    typedef logic [PAL_AW-1:0] pal_addr_t;

    // One data byte
    typedef logic [DATA_W-1:0] cpu_data_t;

endpackage

// ==== src/pal_cpu_if.sv ====
//********************
// CPU palette bus between mixer top and RAM
// Writes need cs and cen high with rnw low
// Reads are unstrobed, rdata lags addr by one clk
//********************

`timescale 1ns/10ps

interface pal_cpu_if;

    import cpu_bus_pkg::*;

    // Chip select for the palette
    logic      cs;
    // High for read, low for write
    logic      rnw;
    // CPU cycle enable
    logic      cen;
    // Byte address
    pal_addr_t addr;
    // Write data from the CPU
    cpu_data_t wdata;
    // Registered readback
    cpu_data_t rdata;

    // Mixer top drives the bus
    modport cpu (
        output cs,
        output rnw,
        output cen,
        output addr,
        output wdata,
        input  rdata
    );

    // Palette RAM answers it
    modport ram (
        input  cs,
        input  rnw,
        input  cen,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== src/pal_ram.sv ====
//********************
// Dual port palette RAM on a single clock
// CPU port reads old data on a same address write
// Video port is read only, both reads registered
//********************

`timescale 1ns/10ps

module pal_ram (
    input  logic                   clk,
    pal_cpu_if.ram                 bus,
    input  cpu_bus_pkg::pal_addr_t vid_addr,
    output cpu_bus_pkg::cpu_data_t vid_data
);

    import cpu_bus_pkg::*;

    // Palette storage, contents survive reset
    cpu_data_t mem [PAL_BYTES];

    // Write strobe
    logic we;

    // Write only when selected, enabled and not reading
    assign we = bus.cs & bus.cen & ~bus.rnw;

    // CPU port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[bus.addr] <= bus.wdata;
        end
        // Readback of the address presented this cycle
        bus.rdata <= mem[bus.addr];
    end

    // Video port
    always_ff @(posedge clk) begin
        // Byte is ready one clk after its address
        vid_data <= mem[vid_addr];
    end

endmodule

// ==== src/colour_fetch.sv ====
//********************
// Palette fetch for one pixel every two clk
// pxl_cen must be high on every second clk
// Low byte is read first, high byte second
// Colour is valid two pxl_cen after the codes
//********************

`timescale 1ns/10ps

module colour_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  video_pkg::layer1_pxl_t   gfx1_pxl,
    input  video_pkg::layer2_pxl_t   gfx2_pxl,
    output cpu_bus_pkg::pal_addr_t   vid_addr,
    input  cpu_bus_pkg::cpu_data_t   vid_data,
    output video_pkg::rgb15_t        colour
);

    import video_pkg::*;
    import cpu_bus_pkg::*;

    // Layer codes held for the whole fetch
    layer1_pxl_t gfx1_q;
    layer2_pxl_t gfx2_q;

    // Byte select, low during the cycle after pxl_cen
    logic half;

    // Last two returned bytes, newest at the top
    logic [2*DATA_W-1:0] byte_sr;

    // Assembled word from the two bytes
    rgb15_t colour_word;

    // Code capture once per pixel
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            gfx1_q <= gfx1_pxl;
            gfx2_q <= gfx2_pxl;
        end
    end

    // Half bit sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            half <= 1'b0;
        end else if (pxl_cen) begin
            // Next cycle asks for the low byte
            half <= 1'b0;
        end else begin
            // High byte lands in the pxl_cen cycle
            half <= ~half;
        end
    end

    // Bank, layer 2 MSB, half, layer 2 low bits, layer 1 low bits
    assign vid_addr = {gfx1_q[4], gfx2_q[3], half, gfx2_q[2:0], gfx1_q[3:0]};

    // Returned bytes shift in from the top every clk
    always_ff @(posedge clk) begin
        byte_sr <= {vid_data, byte_sr[2*DATA_W-1:DATA_W]};
    end

    // High byte bits 6 to 0 over the full low byte
    assign colour_word = {byte_sr[DATA_W +: HI_BITS], byte_sr[DATA_W-1:0]};

    // Colour register, one word per pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            colour <= '0;
        end else if (pxl_cen) begin
            // Both bytes of the older pixel are in place here
            colour <= colour_word;
        end
    end

endmodule

// ==== src/blank_delay.sv ====
//********************
// Blanking alignment and colour blackout
// DLY counts pxl_cen from blank sampling to LHBL_dly
// DLY must be at least 1 and match the colour latency
//********************

`timescale 1ns/10ps

module blank_delay #(
    parameter int DLY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic              LHBL,
    input  logic              LVBL,
    input  video_pkg::rgb15_t colour_in,
    output logic              LHBL_dly,
    output logic              LVBL_dly,
    output video_pkg::rgb15_t colour_out
);

    // Blanking history, stage 0 is the newest sample
    logic [DLY-1:0] hbl_sr;
    logic [DLY-1:0] vbl_sr;

    // Blanking state that goes out with this colour
    logic active;

    // Both blanks high means visible video
    assign active = hbl_sr[DLY-1] & vbl_sr[DLY-1];

    // Shift and output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts in blanking
            hbl_sr     <= '0;
            vbl_sr     <= '0;
            LHBL_dly   <= 1'b0;
            LVBL_dly   <= 1'b0;
            colour_out <= '0;
        end else if (pxl_cen) begin
            hbl_sr[0] <= LHBL;
            vbl_sr[0] <= LVBL;
            for (int i = 1; i < DLY; i++) begin
                hbl_sr[i] <= hbl_sr[i-1];
                vbl_sr[i] <= vbl_sr[i-1];
            end
            // Outputs change together with the colour
            LHBL_dly <= hbl_sr[DLY-1];
            LVBL_dly <= vbl_sr[DLY-1];
            // Black while either blank is asserted
            colour_out <= active ? colour_in : '0;
        end
    end

endmodule

// ==== src/colmix_top.sv ====
//********************
// Colour mixer top, single clock domain
// pxl_cen must pulse on every second clk
// Colour for codes at pxl_cen k shows after pxl_cen k+3
//********************

`timescale 1ns/10ps

module colmix_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      LHBL,
    input  logic                      LVBL,
    output logic                      LHBL_dly,
    output logic                      LVBL_dly,
    // CPU palette access
    input  logic                      pal_cs,
    input  logic                      cpu_rnw,
    input  logic                      cpu_cen,
    input  cpu_bus_pkg::pal_addr_t    cpu_addr,
    input  cpu_bus_pkg::cpu_data_t    cpu_dout,
    output cpu_bus_pkg::cpu_data_t    pal_dout,
    // Layer codes
    input  video_pkg::layer1_pxl_t    gfx1_pxl,
    input  video_pkg::layer2_pxl_t    gfx2_pxl,
    // Colour outputs
    output video_pkg::colour_comp_t   red,
    output video_pkg::colour_comp_t   green,
    output video_pkg::colour_comp_t   blue
);

    import video_pkg::*;
    import cpu_bus_pkg::*;

    // Video read port
    pal_addr_t vid_addr;
    cpu_data_t vid_data;

    // Colour before and after blanking
    rgb15_t fetch_colour;
    rgb15_t mixed_colour;

    // CPU bus into the RAM
    pal_cpu_if pal_bus ();

    assign pal_bus.cs    = pal_cs;
    assign pal_bus.rnw   = cpu_rnw;
    assign pal_bus.cen   = cpu_cen;
    assign pal_bus.addr  = cpu_addr;
    assign pal_bus.wdata = cpu_dout;
    assign pal_dout      = pal_bus.rdata;

    pal_ram u_ram (
        .clk      (clk),
        .bus      (pal_bus),
        .vid_addr (vid_addr),
        .vid_data (vid_data)
    );

    // Two byte fetch per pixel
    colour_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx1_pxl (gfx1_pxl),
        .gfx2_pxl (gfx2_pxl),
        .vid_addr (vid_addr),
        .vid_data (vid_data),
        .colour   (fetch_colour)
    );

    // Blank delay matches fetch plus output register
    blank_delay #(
        .DLY (PIXEL_DLY)
    ) u_blank (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .LHBL       (LHBL),
        .LVBL       (LVBL),
        .colour_in  (fetch_colour),
        .LHBL_dly   (LHBL_dly),
        .LVBL_dly   (LVBL_dly),
        .colour_out (mixed_colour)
    );

    // Blue high, red low
    assign {blue, green, red} = mixed_colour;

endmodule

// ==== tb/colmix_checker.sv ====
//********************
// Concurrent checks bound into the mixer top
// Blank history restarts in blanking on reset
// Only checked on pxl_cen edges for the delay
//********************

`timescale 1ns/10ps

module colmix_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    pxl_cen,
    input logic                    LHBL,
    input logic                    LVBL,
    input logic                    LHBL_dly,
    input logic                    LVBL_dly,
    input video_pkg::colour_comp_t red,
    input video_pkg::colour_comp_t green,
    input video_pkg::colour_comp_t blue
);

    import video_pkg::*;

    // Blank inputs of the last pixels, newest in bit 0
    logic [PIXEL_DLY-1:0] hbl_hist;
    logic [PIXEL_DLY-1:0] vbl_hist;

    // Number of assertion failures so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_hist <= '0;
            vbl_hist <= '0;
        end else if (pxl_cen) begin
            hbl_hist <= {hbl_hist[PIXEL_DLY-2:0], LHBL};
            vbl_hist <= {vbl_hist[PIXEL_DLY-2:0], LVBL};
        end
    end

    // Delayed blanks take the sample from PIXEL_DLY pixels back
    hbl_follows: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> (LHBL_dly == $past(hbl_hist[PIXEL_DLY-1])))
    else begin
        fail_count++;
        $error("LHBL_dly does not follow LHBL by %0d pixels", PIXEL_DLY);
    end

    vbl_follows: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> (LVBL_dly == $past(vbl_hist[PIXEL_DLY-1])))
    else begin
        fail_count++;
        $error("LVBL_dly does not follow LVBL by %0d pixels", PIXEL_DLY);
    end

    // No colour leaks out while blanked
    black_in_blank: assert property (@(posedge clk) disable iff (rst)
        (!LHBL_dly || !LVBL_dly) |-> ({blue, green, red} == '0))
    else begin
        fail_count++;
        $error("colour is not black during blanking");
    end

    // Reset leaves the outputs in blanking with black colour
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!LHBL_dly && !LVBL_dly && ({blue, green, red} == '0)))
    else begin
        fail_count++;
        $error("outputs not cleared by reset");
    end

endmodule

bind colmix_top colmix_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .pxl_cen  (pxl_cen),
    .LHBL     (LHBL),
    .LVBL     (LVBL),
    .LHBL_dly (LHBL_dly),
    .LVBL_dly (LVBL_dly),
    .red      (red),
    .green    (green),
    .blue     (blue)
);

// ==== tb/colmix_tb.sv ====
//********************
// Testbench for the colour mixer top
// Palette model follows every write made here
// CPU writes in active video land on pxl_cen edges only
//********************

`timescale 1ns/10ps

module colmix_tb;

    import video_pkg::*;
    import cpu_bus_pkg::*;

    localparam int SEED     = 84;
    localparam int N_RDBK   = 32;
    localparam int N_LOOKUP = 64;
    localparam int N_RESET  = 8;
    localparam int N_BLANK  = 96;
    localparam int N_MID    = 32;
    // Pixels left to drain after each test
    localparam int DRAIN    = PIXEL_DLY + 2;

    // Pixel periods of all tests, a CPU access takes half a pixel
    localparam int TEST_PIXELS = N_RDBK + PAL_BYTES / 2 + N_LOOKUP + N_RESET + 4
                               + N_BLANK + 2 * N_MID + 6 * DRAIN;

    // Expected outputs for one sampled pixel
    typedef struct packed {
        logic   hbl;
        logic   vbl;
        rgb15_t colour;
    } pix_exp_t;

    logic         clk = 1'b0;
    logic         pxl_cen = 1'b0;
    logic         rst;
    logic         LHBL;
    logic         LVBL;
    logic         LHBL_dly;
    logic         LVBL_dly;
    logic         pal_cs;
    logic         cpu_rnw;
    logic         cpu_cen;
    pal_addr_t    cpu_addr;
    cpu_data_t    cpu_dout;
    cpu_data_t    pal_dout;
    layer1_pxl_t  gfx1_pxl;
    layer2_pxl_t  gfx2_pxl;
    colour_comp_t red;
    colour_comp_t green;
    colour_comp_t blue;

    // Reference palette
    cpu_data_t pal_model [PAL_BYTES];

    // Outputs still in flight, oldest first, with their test names
    pix_exp_t exp_q [$];
    string    name_q [$];

    string test_name = "startup";
    int    check_count = 0;
    int    err_count = 0;
    int    test_count = 0;
    int    test_errs = 0;

    colmix_top uut (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .pal_cs   (pal_cs),
        .cpu_rnw  (cpu_rnw),
        .cpu_cen  (cpu_cen),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .pal_dout (pal_dout),
        .gfx1_pxl (gfx1_pxl),
        .gfx2_pxl (gfx2_pxl),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Pixel enable on every second clk
    always @(negedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // Bank, layer 2 MSB, half, layer 2 low bits, layer 1 low bits
    function automatic pal_addr_t pal_index(layer1_pxl_t l1, layer2_pxl_t l2, logic half);
        return {l1[4], l2[3], half, l2[2:0], l1[3:0]};
    endfunction

    // Colour from the model, black when either blank is low
    function automatic pix_exp_t expect_pixel(layer1_pxl_t l1, layer2_pxl_t l2,
                                              logic hbl, logic vbl);
        pix_exp_t  e;
        cpu_data_t lo;
        cpu_data_t hi;
        e.hbl = hbl;
        e.vbl = vbl;
        e.colour = '0;
        if (hbl && vbl) begin
            lo = pal_model[pal_index(l1, l2, 1'b0)];
            hi = pal_model[pal_index(l1, l2, 1'b1)];
            // Bit 7 of the high byte is unused
            e.colour = {hi[6:0], lo};
        end
        return e;
    endfunction

    task automatic wait_pixel_edge();
        do begin
            @(posedge clk);
        end while (!pxl_cen);
    endtask

    // Inputs set here are sampled on the next pxl_cen edge
    task automatic drive_pixel(layer1_pxl_t l1, layer2_pxl_t l2, logic hbl, logic vbl);
        wait_pixel_edge();
        @(negedge clk);
        gfx1_pxl = l1;
        gfx2_pxl = l2;
        LHBL     = hbl;
        LVBL     = vbl;
    endtask

    task automatic random_pixel(logic hbl, logic vbl);
        drive_pixel(layer1_pxl_t'($urandom), layer2_pxl_t'($urandom), hbl, vbl);
    endtask

    // Starts and ends on a falling edge
    task automatic cpu_write(pal_addr_t addr, cpu_data_t data);
        pal_cs   = 1'b1;
        cpu_cen  = 1'b1;
        cpu_rnw  = 1'b0;
        cpu_addr = addr;
        cpu_dout = data;
        pal_model[addr] = data;
        @(negedge clk);
        pal_cs  = 1'b0;
        cpu_cen = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    // Readback is due one clk after the address
    task automatic cpu_read_check(pal_addr_t addr);
        pal_cs   = 1'b1;
        cpu_cen  = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_addr = addr;
        @(negedge clk);
        pal_cs  = 1'b0;
        cpu_cen = 1'b0;
        check_count++;
        assert (pal_dout === pal_model[addr])
        else begin
            err_count++;
            $display("mismatch %s addr %h expected %h actual %h",
                     test_name, addr, pal_model[addr], pal_dout);
        end
    endtask

    task automatic check_pixel(pix_exp_t e, string name);
        pix_exp_t got;
        got = {LHBL_dly, LVBL_dly, blue, green, red};
        check_count++;
        assert (got === e)
        else begin
            err_count++;
            $display("mismatch %s expected %h actual %h", name, e, got);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = err_count;
    endtask

    // Lets the last pixels of the test reach the output
    task automatic finish_test();
        repeat (DRAIN) wait_pixel_edge();
        @(negedge clk);
        test_count++;
        $display("test %s finished with %0d errors", test_name, err_count - test_errs);
    endtask

    // Output checks, one per pixel, PIXEL_DLY pixels after sampling
    initial begin : pixel_monitor
        forever begin
            wait_pixel_edge();
            if (rst) begin
                // Reset state stands in for the pixels before it
                exp_q.delete();
                name_q.delete();
                repeat (PIXEL_DLY) begin
                    exp_q.push_back('0);
                    name_q.push_back(test_name);
                end
            end else begin
                exp_q.push_back(expect_pixel(gfx1_pxl, gfx2_pxl, LHBL, LVBL));
                name_q.push_back(test_name);
                @(negedge clk);
                check_pixel(exp_q.pop_front(), name_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        #(2 * TEST_PIXELS * 40);
        $display("watchdog timeout, tests still running after %0d ns", 2 * TEST_PIXELS * 40);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        pal_addr_t   rd_addr [N_RDBK];
        layer1_pxl_t l1;
        layer2_pxl_t l2;
        logic        half;
        void'($urandom(SEED));
        rst      = 1'b1;
        LHBL     = 1'b0;
        LVBL     = 1'b0;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        gfx1_pxl = '0;
        gfx2_pxl = '0;
        apply_reset();

        // Blanked video, palette only touched by the CPU
        start_test("cpu_readback");
        for (int i = 0; i < N_RDBK; i++) begin
            rd_addr[i] = pal_addr_t'($urandom);
            cpu_write(rd_addr[i], cpu_data_t'($urandom));
        end
        for (int i = 0; i < N_RDBK; i++) begin
            cpu_read_check(rd_addr[i]);
        end
        finish_test();

        // Whole palette written while blanked, then active video
        start_test("colour_lookup");
        for (int a = 0; a < PAL_BYTES; a++) begin
            cpu_write(pal_addr_t'(a), cpu_data_t'($urandom));
        end
        repeat (N_LOOKUP) random_pixel(1'b1, 1'b1);
        finish_test();

        // Blanks already high when reset drops
        start_test("reset");
        LHBL = 1'b1;
        LVBL = 1'b1;
        apply_reset();
        repeat (N_RESET) random_pixel(1'b1, 1'b1);
        finish_test();

        start_test("blanking");
        repeat (N_BLANK) random_pixel(($urandom % 4) != 0, ($urandom % 8) != 0);
        finish_test();

        // Each write hits a byte of the pixel sampled on the same edge
        start_test("mid_frame");
        for (int i = 0; i < N_MID; i++) begin
            l1   = layer1_pxl_t'($urandom);
            l2   = layer2_pxl_t'($urandom);
            half = 1'($urandom);
            drive_pixel(l1, l2, 1'b1, 1'b1);
            @(negedge clk);
            cpu_write(pal_index(l1, l2, half), cpu_data_t'($urandom));
        end
        finish_test();

        // Bound assertion failures count as errors too
        err_count += uut.u_checker.fail_count;
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/video_pkg.sv
src/cpu_bus_pkg.sv
src/pal_cpu_if.sv
src/pal_ram.sv
src/colour_fetch.sv
src/blank_delay.sv
src/colmix_top.sv
tb/colmix_checker.sv
tb/colmix_tb.sv
